// ==== list.f ====
verilog/ro_pkg.sv
verilog/free_list.sv
verilog/mshr_if.sv
verilog/line_splitter.sv
verilog/thread_context.sv
verilog/line_unpacker.sv
verilog/read_only_stage.sv
bench/read_only_stage_chk.sv
bench/tb_read_only_stage.sv

// ==== Bender.yml ====
package:
  name: read_only_stage

sources:
  # design, package first
  - verilog/ro_pkg.sv
  - verilog/free_list.sv
  - verilog/mshr_if.sv
  - verilog/line_splitter.sv
  - verilog/thread_context.sv
  - verilog/line_unpacker.sv
  - verilog/read_only_stage.sv

  # testbench and bound checker
  - target: simulation
    files:
      - bench/read_only_stage_chk.sv
      - bench/tb_read_only_stage.sv

// ==== bench/tb_read_only_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_read_only_stage;
   localparam int N_THREADS = 4;
   localparam int N_IDS = 8;
   localparam int IW = $clog2(N_IDS);
   localparam int N_REQ = 40;

   logic clk, rstn;
   logic req_valid, req_ready, arvalid, arready, rvalid, rready;
   logic out_valid, out_ready, out_last, idle;
   ro_pkg::addr_t req_addr, araddr;
   ro_pkg::n_words_t req_n_words, out_index;
   ro_pkg::tag_t req_tag, out_tag;
   ro_pkg::word_t out_data;
   ro_pkg::line_t rdata;
   logic [IW-1:0] arid, rid;

   logic [31:0] seed = 32'h0a83_56c2;
   // per-tag scoreboard
   bit live [256];
   ro_pkg::addr_t base [256];
   int n_words [256];
   int n_seen [256];
   logic [63:0] seen [256];
   ro_pkg::addr_t exp_ar [$]; // read start addresses in issue order
   ro_pkg::addr_t mem_addr [$]; // reads waiting at memory
   logic [IW-1:0] mem_id [$];
   int r_sel = -1; // read the memory presents or -1
   bit req_taken = 1'b0;
   int n_sent = 0;
   int n_done = 0;

   read_only_stage #(.N_THREADS(N_THREADS), .N_IDS(N_IDS)) UUT (.*);

   function automatic logic [31:0] next_random();
      seed = seed * 32'd1664525 + 32'd1013904223;
      return {16'h0, seed[31:16]}; // low bits of an lcg repeat quickly
   endfunction

   // each word of a line holds its own byte address
   function automatic ro_pkg::line_t line_at(input ro_pkg::addr_t addr);
      ro_pkg::line_t line;
      for (int i = 0; i < ro_pkg::LINE_WORDS; i++) begin
         line[i*32 +: 32] = {addr[31:6], 6'b0} + 32'(4 * i);
      end
      return line;
   endfunction

   task automatic expect_reads(input ro_pkg::addr_t addr, input int n);
      int room;
      while (n > 0) begin
         room = ro_pkg::LINE_WORDS - int'(addr[5:2]);
         exp_ar.push_back(addr);
         n -= (n < room) ? n : room;
         addr = {addr[31:6] + 1'b1, 6'b0}; // next line start
      end
   endtask

   task automatic stop_run();
      $display("FAIL: see errors above");
      $fatal(1, "run stopped on first error");
   endtask

   task automatic show_mismatch(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
      $display("** Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
      stop_run();
   endtask

   task automatic show_fault(input string what);
      $display("** Error at %0t ns: %s", $time, what);
      stop_run();
   endtask

   task automatic post_request();
      req_addr = {14'h0, 16'(next_random()), 2'b00};
      req_n_words = ro_pkg::n_words_t'(next_random() % 64 + 1);
      req_tag = ro_pkg::tag_t'(next_random());
      while (live[req_tag]) begin
         req_tag = ro_pkg::tag_t'(next_random()); // keep tags unique in flight
      end
      req_valid = 1'b1;
      n_sent++;
   endtask

   task automatic drive_cycle();
      arready = (next_random() % 4) != 0;
      out_ready = (next_random() % 4) != 0;
      if (req_taken) begin
         req_valid = 1'b0;
         req_taken = 1'b0;
      end
      if (!req_valid && n_sent < N_REQ && next_random() % 3 == 0) begin
         post_request();
      end
      // answer any waiting read, not only the oldest
      if (r_sel < 0 && mem_id.size() > 0 && next_random() % 4 != 0) begin
         r_sel = int'(next_random() % mem_id.size());
      end
      rvalid = (r_sel >= 0);
      if (r_sel >= 0) begin
         rid = mem_id[r_sel];
         rdata = line_at(mem_addr[r_sel]);
      end
   endtask

   task automatic check_word();
      a_tag_live: assert (live[out_tag])
         else show_fault("out_tag does not belong to a request in flight");
      a_data: assert (out_data == base[out_tag] + 4 * out_index)
         else show_mismatch("out_data", out_data, base[out_tag] + 4 * out_index);
      a_index: assert (int'(out_index) < n_words[out_tag] && !seen[out_tag][out_index])
         else show_fault("out_index out of range or sent twice");
      seen[out_tag][out_index] = 1'b1;
      n_seen[out_tag]++;
      a_last: assert (out_last == (n_seen[out_tag] == n_words[out_tag]))
         else show_mismatch("out_last", out_last, n_seen[out_tag] == n_words[out_tag]);
      if (n_seen[out_tag] == n_words[out_tag]) begin
         live[out_tag] = 1'b0;
         n_done++;
      end
   endtask

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   initial begin
      #(N_REQ * 64 * 8 * 10);
      show_fault("timeout, requests did not complete in time");
   end

   always @(negedge clk) begin
      if (UUT.chk.errors != 0) begin
         show_fault("bound checker assertion failed");
      end
   end

   always @(posedge clk) begin
      if (rstn) begin
         if (req_valid && req_ready) begin
            live[req_tag] = 1'b1;
            base[req_tag] = req_addr;
            n_words[req_tag] = int'(req_n_words);
            n_seen[req_tag] = 0;
            seen[req_tag] = '0;
            expect_reads(req_addr, int'(req_n_words));
            req_taken = 1'b1;
         end
         if (arvalid && arready) begin
            a_ar_expected: assert (exp_ar.size() != 0)
               else show_fault("read issued with no request pending");
            a_ar_addr: assert (araddr == exp_ar[0])
               else show_mismatch("araddr", araddr, exp_ar[0]);
            void'(exp_ar.pop_front());
            mem_addr.push_back(araddr);
            mem_id.push_back(arid);
         end
         if (rvalid && rready) begin
            mem_addr.delete(r_sel);
            mem_id.delete(r_sel);
            r_sel = -1;
         end
         if (out_valid && out_ready) begin
            check_word();
         end
      end
   end

   initial begin
      rstn = 1'b0;
      req_valid = 1'b0;
      req_addr = '0;
      req_n_words = '0;
      req_tag = '0;
      arready = 1'b0;
      rvalid = 1'b0;
      rid = '0;
      rdata = '0;
      out_ready = 1'b0;
      repeat (3) @(posedge clk);
      @(negedge clk);
      rstn = 1'b1;
      a_idle_reset: assert (idle) else show_fault("idle low after reset");
      while (n_done < N_REQ) begin
         @(negedge clk);
         drive_cycle();
      end
      @(negedge clk);
      a_idle_end: assert (idle) else show_fault("idle low after the last word");
      if (exp_ar.size() != 0 || mem_id.size() != 0) begin
         show_fault("reads left over after the last request");
      end else begin
         $display("PASS: all tests");
         $finish;
      end
   end

endmodule

`default_nettype wire

// ==== bench/read_only_stage_chk.sv ====
`timescale 1ns/1ns
`default_nettype none

module read_only_stage_chk #(
   parameter int N_THREADS = 4,
   parameter int N_IDS = 8,
   localparam int IW = (N_IDS > 1) ? $clog2(N_IDS) : 1
) (
   input wire clk,
   input wire rstn,
   input wire req_valid,
   input wire req_ready,
   input wire arvalid,
   input wire arready,
   input wire ro_pkg::addr_t araddr,
   input wire [IW-1:0] arid,
   input wire rvalid,
   input wire rready,
   input wire [IW-1:0] rid,
   input wire out_valid,
   input wire out_ready,
   input wire ro_pkg::word_t out_data,
   input wire ro_pkg::tag_t out_tag,
   input wire ro_pkg::n_words_t out_index,
   input wire out_last,
   input wire idle
);
   int outstanding; // reads issued and not yet answered
   int in_flight;
   logic [N_IDS-1:0] pending; // ids waiting for their line
   int errors = 0;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         outstanding <= 0;
         in_flight <= 0;
         pending <= '0;
      end else begin
         outstanding <= outstanding + int'(arvalid && arready) - int'(rvalid && rready);
         in_flight <= in_flight + int'(req_valid && req_ready)
            - int'(out_valid && out_ready && out_last);
         if (rvalid && rready) begin
            pending[rid] <= 1'b0;
         end
         if (arvalid && arready) begin
            pending[arid] <= 1'b1;
         end
      end
   end

   a_out_hold: assert property (@(posedge clk) disable iff (!rstn)
      out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_tag)
         && $stable(out_index) && $stable(out_last))
      else begin
         $error("output beat changed while stalled");
         errors++;
      end

   a_ar_hold: assert property (@(posedge clk) disable iff (!rstn)
      arvalid && !arready |=> arvalid && $stable(araddr) && $stable(arid))
      else begin
         $error("read address changed while stalled");
         errors++;
      end

   a_reads_limit: assert property (@(posedge clk) disable iff (!rstn)
      outstanding <= N_IDS)
      else begin
         $error("more reads outstanding than ids");
         errors++;
      end

   // an id goes out again only after its line came back
   a_id_free: assert property (@(posedge clk) disable iff (!rstn)
      arvalid && arready |-> !pending[arid])
      else begin
         $error("arid reused while its response is pending");
         errors++;
      end

   a_threads_limit: assert property (@(posedge clk) disable iff (!rstn)
      in_flight <= N_THREADS && (in_flight == N_THREADS -> !req_ready))
      else begin
         $error("requests in flight exceed the thread pool");
         errors++;
      end

   a_idle: assert property (@(posedge clk) disable iff (!rstn)
      idle == (in_flight == 0))
      else begin
         $error("idle does not match requests in flight");
         errors++;
      end

endmodule

bind read_only_stage read_only_stage_chk #(
   .N_THREADS(N_THREADS),
   .N_IDS(N_IDS)
) chk (.*);

`default_nettype wire

// ==== verilog/read_only_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module read_only_stage #(
   parameter int N_THREADS = 4,
   parameter int N_IDS = 8,
   localparam int IW = (N_IDS > 1) ? $clog2(N_IDS) : 1,
   localparam int TW = (N_THREADS > 1) ? $clog2(N_THREADS) : 1
) (
   input wire clk,
   input wire rstn,

   input wire req_valid,
   output logic req_ready,
   input wire ro_pkg::addr_t req_addr,
   input wire ro_pkg::n_words_t req_n_words,
   input wire ro_pkg::tag_t req_tag,

   output logic arvalid,
   input wire arready,
   output ro_pkg::addr_t araddr,
   output logic [IW-1:0] arid,

   input wire rvalid,
   output logic rready,
   input wire [IW-1:0] rid,
   input wire ro_pkg::line_t rdata,

   output logic out_valid,
   input wire out_ready,
   output ro_pkg::word_t out_data,
   output ro_pkg::tag_t out_tag,
   output ro_pkg::n_words_t out_index,
   output logic out_last,

   output logic idle
);
   logic thread_free;
   logic [TW-1:0] thread_next;
   logic thread_take;
   logic id_put;
   logic [IW-1:0] id_put_item;
   logic [TW-1:0] cur_thread; // thread of the line being unpacked
   logic sent;

   mshr_if #(.N_IDS(N_IDS), .N_THREADS(N_THREADS)) mshr ();

   line_splitter #(.N_IDS(N_IDS), .N_THREADS(N_THREADS)) splitter (
      .clk(clk),
      .rstn(rstn),
      .req_valid(req_valid),
      .req_ready(req_ready),
      .req_addr(req_addr),
      .req_n_words(req_n_words),
      .thread_free(thread_free),
      .thread_next(thread_next),
      .thread_take(thread_take),
      .arvalid(arvalid),
      .arready(arready),
      .araddr(araddr),
      .arid(arid),
      .id_put(id_put),
      .id_put_item(id_put_item),
      .mshr(mshr.writer)
   );

   thread_context #(.N_THREADS(N_THREADS)) threads (
      .clk(clk),
      .rstn(rstn),
      .take(thread_take),
      .take_tag(req_tag),
      .take_n_words(req_n_words),
      .free(thread_free),
      .next_thread(thread_next),
      .sent(sent),
      .sent_thread(cur_thread),
      .cur_thread(cur_thread),
      .cur_tag(out_tag),
      .cur_last(out_last),
      .idle(idle)
   );

   line_unpacker #(.N_IDS(N_IDS), .N_THREADS(N_THREADS)) unpacker (
      .clk(clk),
      .rstn(rstn),
      .mshr(mshr.reader),
      .rvalid(rvalid),
      .rready(rready),
      .rid(rid),
      .rdata(rdata),
      .id_put(id_put),
      .id_put_item(id_put_item),
      .out_valid(out_valid),
      .out_ready(out_ready),
      .out_data(out_data),
      .out_index(out_index),
      .cur_thread(cur_thread),
      .sent(sent)
   );

endmodule

`default_nettype wire

// ==== verilog/line_unpacker.sv ====
`timescale 1ns/1ns
`default_nettype none

module line_unpacker #(
   parameter int N_IDS = 8,
   parameter int N_THREADS = 4,
   localparam int IW = (N_IDS > 1) ? $clog2(N_IDS) : 1,
   localparam int TW = (N_THREADS > 1) ? $clog2(N_THREADS) : 1
) (
   input wire clk,
   input wire rstn,
   mshr_if.reader mshr,
   input wire rvalid,
   output logic rready,
   input wire [IW-1:0] rid,
   input wire ro_pkg::line_t rdata,
   output logic id_put,
   output logic [IW-1:0] id_put_item,
   output logic out_valid,
   input wire out_ready,
   output ro_pkg::word_t out_data,
   output ro_pkg::n_words_t out_index,
   output logic [TW-1:0] cur_thread,
   output logic sent
);
   localparam int WB = $bits(ro_pkg::word_t);

   // miss-status table, indexed by read id
   ro_pkg::word_mask_t tbl_mask [N_IDS];
   logic [TW-1:0] tbl_thread [N_IDS];
   ro_pkg::n_words_t tbl_start [N_IDS];

   logic held; // a line is being unpacked
   ro_pkg::line_t line_r;
   ro_pkg::word_mask_t mask_r;
   ro_pkg::word_mask_t mask_next;
   ro_pkg::word_idx_t sel;
   logic last_word;
   logic r_fire;

   always_ff @(posedge clk) begin
      if (mshr.valid) begin
         tbl_mask[mshr.id] <= mshr.mask;
         tbl_thread[mshr.id] <= mshr.thread;
         tbl_start[mshr.id] <= mshr.start_index;
      end
   end

   always_comb begin
      sel = '0;
      for (int i = ro_pkg::LINE_WORDS - 1; i >= 0; i--) begin
         if (mask_r[i]) begin
            sel = ro_pkg::word_idx_t'(i); // lowest wanted word wins
         end
      end
      mask_next = mask_r;
      mask_next[sel] = 1'b0;
   end

   assign out_valid = held;
   assign out_data = line_r[sel*WB +: WB];
   assign sent = out_valid && out_ready;
   assign last_word = (mask_next == '0);

   // take a new line once the held one drains
   assign rready = !held || (sent && last_word);
   assign r_fire = rvalid && rready;
   assign id_put = r_fire; // id is free as soon as its data is in
   assign id_put_item = rid;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         held <= 1'b0;
      end else if (r_fire) begin
         held <= 1'b1;
      end else if (sent && last_word) begin
         held <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (r_fire) begin
         line_r <= rdata;
         mask_r <= tbl_mask[rid];
         cur_thread <= tbl_thread[rid];
         out_index <= tbl_start[rid];
      end else if (sent) begin
         mask_r <= mask_next;
         out_index <= out_index + 1'b1;
      end
   end

endmodule

`default_nettype wire

// ==== verilog/thread_context.sv ====
`timescale 1ns/1ns
`default_nettype none

module thread_context #(
   parameter int N_THREADS = 4,
   localparam int TW = (N_THREADS > 1) ? $clog2(N_THREADS) : 1
) (
   input wire clk,
   input wire rstn,
   input wire take,
   input wire ro_pkg::tag_t take_tag,
   input wire ro_pkg::n_words_t take_n_words,
   output logic free,
   output logic [TW-1:0] next_thread,
   input wire sent,
   input wire [TW-1:0] sent_thread,
   input wire [TW-1:0] cur_thread,
   output ro_pkg::tag_t cur_tag,
   output logic cur_last,
   output logic idle
);
   typedef logic [TW-1:0] thread_t;

   ro_pkg::tag_t tags [N_THREADS];
   ro_pkg::n_words_t remaining [N_THREADS]; // words still to send per thread
   logic pool_empty;
   logic done;

   free_list #(
      .item_t(thread_t),
      .DEPTH(N_THREADS)
   ) thread_pool (
      .clk(clk),
      .rstn(rstn),
      .put(done),
      .put_item(sent_thread),
      .take(take),
      .next_item(next_thread),
      .empty(pool_empty),
      .full(idle) // every thread back in the pool
   );

   assign free = !pool_empty;

   // thread retires with its final word
   assign done = sent && (remaining[sent_thread] == 8'd1);

   assign cur_tag = tags[cur_thread];
   assign cur_last = (remaining[cur_thread] == 8'd1);

   always_ff @(posedge clk) begin
      if (take) begin
         tags[next_thread] <= take_tag;
         remaining[next_thread] <= take_n_words;
      end
      if (sent) begin
         remaining[sent_thread] <= remaining[sent_thread] - 1'b1;
      end
   end

endmodule

`default_nettype wire

// ==== verilog/line_splitter.sv ====
`timescale 1ns/1ns
`default_nettype none

module line_splitter #(
   parameter int N_IDS = 8,
   parameter int N_THREADS = 4,
   localparam int IW = (N_IDS > 1) ? $clog2(N_IDS) : 1,
   localparam int TW = (N_THREADS > 1) ? $clog2(N_THREADS) : 1
) (
   input wire clk,
   input wire rstn,
   input wire req_valid,
   output logic req_ready,
   input wire ro_pkg::addr_t req_addr,
   input wire ro_pkg::n_words_t req_n_words,
   input wire thread_free,
   input wire [TW-1:0] thread_next,
   output logic thread_take,
   output logic arvalid,
   input wire arready,
   output ro_pkg::addr_t araddr,
   output logic [IW-1:0] arid,
   input wire id_put,
   input wire [IW-1:0] id_put_item,
   mshr_if.writer mshr
);
   localparam int OW = $clog2(ro_pkg::LINE_WORDS);
   localparam int LINE_BYTES = ro_pkg::LINE_WORDS * 4;

   typedef logic [IW-1:0] id_t;

   logic busy; // lines of the current request still to issue
   ro_pkg::addr_t cur_addr;
   ro_pkg::n_words_t words_left;
   ro_pkg::n_words_t start_idx;
   logic [TW-1:0] cur_thread;
   ro_pkg::word_idx_t offset;
   ro_pkg::n_words_t room;
   ro_pkg::n_words_t rd_words;
   ro_pkg::word_mask_t wanted;
   logic last_read;
   logic ar_fire;
   logic id_empty;
   id_t id_next;

   free_list #(
      .item_t(id_t),
      .DEPTH(N_IDS)
   ) id_pool (
      .clk(clk),
      .rstn(rstn),
      .put(id_put),
      .put_item(id_put_item),
      .take(ar_fire),
      .next_item(id_next),
      .empty(id_empty),
      .full()
   );

   assign req_ready = !busy && thread_free;
   assign thread_take = req_valid && req_ready;
   assign arvalid = busy && !id_empty; // hold off while no id is free
   assign ar_fire = arvalid && arready;
   assign araddr = cur_addr;
   assign arid = id_next;

   always_comb begin
      offset = cur_addr[OW+1:2];
      room = ro_pkg::n_words_t'(ro_pkg::LINE_WORDS) - ro_pkg::n_words_t'(offset);
      // rest of the line or the words left, whichever is smaller
      last_read = (words_left <= room);
      rd_words = last_read ? words_left : room;
      for (int i = 0; i < ro_pkg::LINE_WORDS; i++) begin
         wanted[i] = (i >= int'(offset)) && (i < int'(offset) + int'(rd_words));
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         busy <= 1'b0;
      end else if (thread_take) begin
         busy <= 1'b1;
      end else if (ar_fire && last_read) begin
         busy <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (thread_take) begin
         cur_addr <= req_addr;
         words_left <= req_n_words;
         start_idx <= '0;
         cur_thread <= thread_next;
      end else if (ar_fire) begin
         cur_addr <= (cur_addr | ro_pkg::addr_t'(LINE_BYTES - 1)) + 1'b1; // next line start
         words_left <= words_left - rd_words;
         start_idx <= start_idx + rd_words;
      end
   end

   assign mshr.valid = ar_fire;
   assign mshr.id = id_next;
   assign mshr.thread = cur_thread;
   assign mshr.mask = wanted;
   assign mshr.start_index = start_idx;

endmodule

`default_nettype wire

// ==== verilog/mshr_if.sv ====
`timescale 1ns/1ns
`default_nettype none

interface mshr_if #(
   parameter int N_IDS = 8,
   parameter int N_THREADS = 4
);
   localparam int IW = (N_IDS > 1) ? $clog2(N_IDS) : 1;
   localparam int TW = (N_THREADS > 1) ? $clog2(N_THREADS) : 1;

   logic valid; // written with the read-address transfer
   logic [IW-1:0] id;
   logic [TW-1:0] thread;
   ro_pkg::word_mask_t mask;
   ro_pkg::n_words_t start_index; // request index of first wanted word

   modport writer (output valid, id, thread, mask, start_index);
   modport reader (input valid, id, thread, mask, start_index);

endinterface

`default_nettype wire

// ==== verilog/free_list.sv ====
`timescale 1ns/1ns
`default_nettype none

module free_list #(
   parameter type item_t = logic [2:0],
   parameter int DEPTH = 8
) (
   input wire clk,
   input wire rstn,
   input wire put,
   input wire item_t put_item,
   input wire take,
   output item_t next_item,
   output logic empty,
   output logic full
);
   localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CW = $clog2(DEPTH + 1);

   item_t mem [DEPTH];
   logic [PW-1:0] head;
   logic [PW-1:0] tail;
   logic [CW-1:0] count; // free identifiers held

   function automatic logic [PW-1:0] wrap_inc(input logic [PW-1:0] p);
      return (p == PW'(DEPTH - 1)) ? '0 : p + 1'b1;
   endfunction

   always_ff @(posedge clk) begin
      if (!rstn) begin
         head <= '0;
         tail <= '0;
         count <= CW'(DEPTH);
         for (int i = 0; i < DEPTH; i++) begin
            mem[i] <= item_t'(i); // every id starts out free
         end
      end else begin
         if (put) begin
            mem[tail] <= put_item;
            tail <= wrap_inc(tail);
         end
         if (take) begin
            head <= wrap_inc(head);
         end
         if (put && !take) begin
            count <= count + 1'b1;
         end else if (take && !put) begin
            count <= count - 1'b1;
         end
      end
   end

   assign next_item = mem[head];
   assign empty = (count == '0);
   assign full = (count == CW'(DEPTH));

endmodule

`default_nettype wire

// ==== verilog/ro_pkg.sv ====
`default_nettype none

package ro_pkg;

   localparam int LINE_WORDS = 16; // words per 64-byte line

   // one data word
   typedef logic [31:0] word_t;

   typedef logic [LINE_WORDS*32-1:0] line_t;

   typedef logic [$clog2(LINE_WORDS)-1:0] word_idx_t; // word position inside a line

   // one bit per word of a line
   typedef logic [LINE_WORDS-1:0] word_mask_t;

   typedef logic [7:0] n_words_t; // request length, legal range 1 to 64

   typedef logic [7:0] tag_t;

   typedef logic [31:0] addr_t; // byte address

endpackage

`default_nettype wire
